//--- branchPredictor.f
+incdir+logic
+incdir+sim
logic/bpuTypesPkg.sv
logic/bpuBusPkg.sv
logic/btbArray.sv
logic/replacePointer.sv
logic/flushSequencer.sv
logic/bpuCsr.sv
logic/bpuTop.sv
sim/bpuTb.sv

//--- Makefile
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module bpuTb \
		-f branchPredictor.f -o bpuTb
	-./obj_dir/bpuTb > $(LOG) 2>&1
	cat $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- sim/bpuTbTasks.svh
`ifndef BPU_TB_TASKS_SVH
`define BPU_TB_TASKS_SVH

`default_nettype none

// ends the run at the first error
task automatic failRun(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "stopping at first error");
endtask

task automatic checkPredict(input predictT got, input predictT exp, input logic [31:0] pcVal);
    if (got !== exp)
        failRun($sformatf("mismatch at %0t ns: pred for pc %h got %h expected %h",
                          $time, pcVal, got, exp));
endtask

task automatic checkBit(input string name, input logic got, input logic exp);
    if (got !== exp)
        failRun($sformatf("mismatch at %0t ns: %s got %b expected %b",
                          $time, name, got, exp));
endtask

task automatic checkWord(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
        failRun($sformatf("mismatch at %0t ns: %s got %h expected %h",
                          $time, name, got, exp));
endtask

// ack is polled at the drive point after each edge
task automatic awaitAck(output logic [31:0] dat);
    int cycles;
    cycles = 0;
    dat = '0;
    @(posedge clk);
    #2;
    while (!wbRsp.ack && cycles < ackTimeout) begin
        @(posedge clk);
        #2;
        cycles++;
    end
    if (!wbRsp.ack) begin
        failRun("no wishbone ack arrived within the timeout");
    end else begin
        dat = wbRsp.dat;
        wbReq = '0;
        // one idle cycle between requests
        @(posedge clk);
        #2;
    end
endtask

task automatic wbWrite(input csrAddrE adr, input logic [31:0] dat);
    logic [31:0] unused;
    wbReq = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
    awaitAck(unused);
endtask

task automatic wbRead(input csrAddrE adr, output logic [31:0] dat);
    wbReq = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: 32'h0};
    awaitAck(dat);
endtask

`default_nettype wire

`endif

//--- sim/bpuTb.sv
`timescale 1ns/1ps
`include "bpu_consts.svh"
`default_nettype none

module bpuTb;
    import bpuTypesPkg::*;
    import bpuBusPkg::*;

    localparam int ackTimeout = 20;
    localparam int idlePolls  = 40;
    localparam logic [5:0] noId = `BTB_NO_ENTRY;

    typedef enum {RESOLVE, COMMIT, LOOKUP, WBWRITE, WBREAD, WAITIDLE} rowKindE;

    // addr is pc, branch address or register; data is target, write data or read value
    typedef struct {
        rowKindE     kind;
        logic [31:0] addr;
        logic [31:0] data;
        logic [5:0]  id;
        logic        taken;
        logic        isJump;
        logic        found;
        logic        multi;
        logic        pulse;
    } stimRowT;

    logic       clk;
    logic       rst;
    logic       pcValid;
    logic [31:0] pc;
    predictT    pred;
    resolveT    resolve;
    commitT     commit;
    logic       branchCommitted;
    wbReqT      wbReq;
    wbRspT      wbRsp;
    stimRowT    rows [$];

    `include "bpuTbTasks.svh"

    bpuTop u_bpuTop (
        .clk             (clk),
        .rst             (rst),
        .pcValid         (pcValid),
        .pc              (pc),
        .pred            (pred),
        .resolve         (resolve),
        .commit          (commit),
        .branchCommitted (branchCommitted),
        .wbReq           (wbReq),
        .wbRsp           (wbRsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic void addRow(rowKindE kind, logic [31:0] addr, logic [31:0] data,
                                   logic [5:0] id, logic taken, logic isJump,
                                   logic found, logic multi, logic pulse);
        stimRowT row;
        row = '{kind, addr, data, id, taken, isJump, found, multi, pulse};
        rows.push_back(row);
    endfunction

    task automatic fillTable();
        //     kind      addr             data   id     tk jp fd mu pl
        // empty after reset
        addRow(LOOKUP,   32'h100,         32'h0,   6'd0, 0, 0, 0, 0, 0);
        addRow(LOOKUP,   32'h300,         32'h0,   6'd0, 0, 0, 0, 0, 0);
        addRow(WBREAD,   32'(REG_STATUS), 32'h0,   6'd0, 0, 0, 0, 0, 0);
        // allocation into entries 0 and 1
        addRow(RESOLVE,  32'h100,         32'h200, noId, 1, 0, 0, 0, 0);
        addRow(LOOKUP,   32'h100,         32'h200, 6'd0, 1, 0, 1, 0, 0);
        addRow(RESOLVE,  32'h108,         32'h180, noId, 1, 1, 0, 0, 0);
        addRow(LOOKUP,   32'h108,         32'h180, 6'd1, 1, 1, 1, 0, 0);
        // not-taken training shifts each outcome into history bit 0
        addRow(COMMIT,   32'h100,         32'h0,   6'd0, 0, 0, 0, 0, 1);
        addRow(LOOKUP,   32'h100,         32'h200, 6'd0, 1, 0, 1, 0, 0);
        addRow(COMMIT,   32'h100,         32'h0,   6'd0, 0, 0, 0, 0, 1);
        addRow(LOOKUP,   32'h100,         32'h200, 6'd0, 1, 0, 1, 0, 0);
        addRow(COMMIT,   32'h100,         32'h0,   6'd0, 0, 0, 0, 0, 1);
        addRow(LOOKUP,   32'h100,         32'h200, 6'd0, 1, 0, 1, 0, 0);
        // counter 0 drops to 01
        addRow(COMMIT,   32'h100,         32'h0,   6'd0, 0, 0, 0, 0, 1);
        addRow(LOOKUP,   32'h100,         32'h200, 6'd0, 0, 0, 1, 0, 0);
        // jump entry never pulses and stays taken with its counter at 01
        addRow(COMMIT,   32'h108,         32'h0,   6'd1, 0, 0, 0, 0, 0);
        addRow(COMMIT,   32'h108,         32'h0,   6'd1, 0, 0, 0, 0, 0);
        addRow(COMMIT,   32'h108,         32'h0,   6'd1, 0, 0, 0, 0, 0);
        addRow(COMMIT,   32'h108,         32'h0,   6'd1, 0, 0, 0, 0, 0);
        addRow(LOOKUP,   32'h108,         32'h180, 6'd1, 1, 1, 1, 0, 0);
        // two branches in one fetch group
        addRow(RESOLVE,  32'h300,         32'h400, noId, 1, 0, 0, 0, 0);
        addRow(RESOLVE,  32'h304,         32'h500, noId, 1, 0, 0, 0, 0);
        addRow(LOOKUP,   32'h300,         32'h400, 6'd2, 1, 0, 1, 1, 0);
        addRow(LOOKUP,   32'h304,         32'h500, 6'd3, 1, 0, 1, 0, 0);
        // statistics
        addRow(WBREAD,   32'(REG_INSERTS), 32'd4,  6'd0, 0, 0, 0, 0, 0);
        addRow(WBREAD,   32'(REG_COMMITS), 32'd4,  6'd0, 0, 0, 0, 0, 0);
        addRow(WBWRITE,  32'(REG_INSERTS), 32'd0,  6'd0, 0, 0, 0, 0, 0);
        addRow(WBWRITE,  32'(REG_COMMITS), 32'd0,  6'd0, 0, 0, 0, 0, 0);
        addRow(WBREAD,   32'(REG_INSERTS), 32'd0,  6'd0, 0, 0, 0, 0, 0);
        addRow(WBREAD,   32'(REG_COMMITS), 32'd0,  6'd0, 0, 0, 0, 0, 0);
        // flush
        addRow(WBWRITE,  32'(REG_CTRL),   32'd1,   6'd0, 0, 0, 0, 0, 0);
        addRow(WBREAD,   32'(REG_STATUS), 32'd1,   6'd0, 0, 0, 0, 0, 0);
        addRow(WAITIDLE, 32'h0,           32'h0,   6'd0, 0, 0, 0, 0, 0);
        addRow(WBREAD,   32'(REG_STATUS), 32'd0,   6'd0, 0, 0, 0, 0, 0);
        addRow(LOOKUP,   32'h100,         32'h0,   6'd0, 0, 0, 0, 0, 0);
        addRow(LOOKUP,   32'h108,         32'h0,   6'd0, 0, 0, 0, 0, 0);
        addRow(LOOKUP,   32'h300,         32'h0,   6'd0, 0, 0, 0, 0, 0);
        addRow(LOOKUP,   32'h304,         32'h0,   6'd0, 0, 0, 0, 0, 0);
    endtask

    // every row starts and ends 2 ns after a rising edge
    task automatic applyRow(input stimRowT row);
        predictT     expPred;
        logic [31:0] rdVal;
        int          polls;
        case (row.kind)
            RESOLVE: begin
                resolve = '{valid: 1'b1, id: row.id, addr: row.addr, dest: row.data,
                            taken: row.taken, isJump: row.isJump};
                @(posedge clk);
                #2;
                resolve = '0;
            end
            COMMIT: begin
                commit = '{valid: 1'b1, isBranch: 1'b1, id: row.id, addr: row.addr[31:2],
                           taken: row.taken};
                @(posedge clk);
                #2;
                commit = '0;
                checkBit("branchCommitted", branchCommitted, row.pulse);
            end
            LOOKUP: begin
                expPred = '0;
                if (row.found) begin
                    expPred.found    = 1'b1;
                    expPred.taken    = row.taken;
                    expPred.isJump   = row.isJump;
                    expPred.multiple = row.multi;
                    expPred.src      = row.addr;
                    expPred.dst      = row.data;
                    expPred.id       = row.id;
                end
                pcValid = 1'b1;
                pc      = row.addr;
                #5;
                checkPredict(pred, expPred, row.addr);
                @(posedge clk);
                #2;
                pcValid = 1'b0;
                pc      = '0;
            end
            WBWRITE: begin
                wbWrite(csrAddrE'(row.addr[3:0]), row.data);
            end
            WBREAD: begin
                wbRead(csrAddrE'(row.addr[3:0]), rdVal);
                checkWord("wbRsp.dat", rdVal, row.data);
            end
            WAITIDLE: begin
                polls = 0;
                rdVal = 32'h1;
                while (rdVal[0]) begin
                    if (polls == idlePolls) begin
                        failRun("flush did not finish, status stayed busy");
                    end else begin
                        wbRead(REG_STATUS, rdVal);
                        polls++;
                    end
                end
            end
            default: begin
                failRun("stimulus table holds an unknown row kind");
            end
        endcase
    endtask

    initial begin
        rst     = 1'b1;
        pcValid = 1'b0;
        pc      = '0;
        resolve = '0;
        commit  = '0;
        wbReq   = '0;
        fillTable();
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        foreach (rows[i])
            applyRow(rows[i]);
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/bpuTop.sv
`timescale 1ns/1ps
`include "bpu_consts.svh"
`default_nettype none

module bpuTop (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         pcValid,
    input  wire [31:0]                  pc,
    output bpuTypesPkg::predictT        pred,
    input  wire bpuTypesPkg::resolveT   resolve,
    input  wire bpuTypesPkg::commitT    commit,
    output logic                        branchCommitted,
    input  wire bpuBusPkg::wbReqT       wbReq,
    output bpuBusPkg::wbRspT            wbRsp
);

    logic [`BTB_IDX_BITS-1:0]   victimIdx;
    logic                       victimBusy;
    logic                       allocated;
    logic                       clearPtr;
    logic                       flushing;
    logic                       wrap;
    logic                       flushStart;
    logic                       ptrStep;

    // walk steps every cycle after the clear cycle
    assign ptrStep = allocated || victimBusy || (flushing && !clearPtr);

    btbArray u_btbArray (
        .clk             (clk),
        .rst             (rst),
        .lookupValid     (pcValid),
        .pc              (pc),
        .pred            (pred),
        .resolve         (resolve),
        .commit          (commit),
        .victimIdx       (victimIdx),
        .flushing        (flushing),
        .victimBusy      (victimBusy),
        .allocated       (allocated),
        .branchCommitted (branchCommitted)
    );

    replacePointer u_replacePointer (
        .clk   (clk),
        .rst   (rst),
        .clear (clearPtr),
        .step  (ptrStep),
        .idx   (victimIdx),
        .wrap  (wrap)
    );

    flushSequencer u_flushSequencer (
        .clk      (clk),
        .rst      (rst),
        .start    (flushStart),
        .wrap     (wrap),
        .clearPtr (clearPtr),
        .flushing (flushing)
    );

    bpuCsr u_bpuCsr (
        .clk             (clk),
        .rst             (rst),
        .wbReq           (wbReq),
        .wbRsp           (wbRsp),
        .allocated       (allocated),
        .branchCommitted (branchCommitted),
        .flushing        (flushing),
        .flushStart      (flushStart)
    );

endmodule

`default_nettype wire

//--- logic/bpuCsr.sv
`timescale 1ns/1ps
`include "bpu_consts.svh"
`default_nettype none

module bpuCsr (
    input  wire                     clk,
    input  wire                     rst,
    input  wire bpuBusPkg::wbReqT   wbReq,
    output bpuBusPkg::wbRspT        wbRsp,
    input  wire                     allocated,
    input  wire                     branchCommitted,
    input  wire                     flushing,
    output logic                    flushStart
);
    import bpuBusPkg::*;

    csrAddrE                addr;
    logic                   accept;
    logic                   wrStrobe;
    logic                   ackQ;
    logic [31:0]            rdData;
    logic [31:0]            readValue;
    logic [`CNT_BITS-1:0]   commitCnt;
    logic [`CNT_BITS-1:0]   insertCnt;

    // new request, the cycle of ack is not a second one
    assign accept   = wbReq.cyc && wbReq.stb && !ackQ;
    assign wrStrobe = accept && wbReq.we;
    assign addr     = csrAddrE'(wbReq.adr);

    assign flushStart = wrStrobe && addr == REG_CTRL && wbReq.dat[0];

    always_comb begin
        case (addr)
            REG_STATUS:  readValue = {31'b0, flushing};
            REG_COMMITS: readValue = 32'(commitCnt);
            REG_INSERTS: readValue = 32'(insertCnt);
            default:     readValue = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst)
            ackQ <= 1'b0;
        else
            ackQ <= accept;
    end

    // value before the ack edge
    always_ff @(posedge clk) begin
        if (accept)
            rdData <= readValue;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            commitCnt <= '0;
            insertCnt <= '0;
        end else begin
            if (wrStrobe && addr == REG_COMMITS)
                commitCnt <= '0;
            else if (branchCommitted && commitCnt != '1)
                commitCnt <= commitCnt + 1'b1;

            if (wrStrobe && addr == REG_INSERTS)
                insertCnt <= '0;
            else if (allocated && insertCnt != '1)
                insertCnt <= insertCnt + 1'b1;
        end
    end

    assign wbRsp = '{ack: ackQ, dat: rdData};

    // single-cycle ack, the master must drop stb before the next request
    assert property (@(posedge clk) disable iff (rst) ackQ |=> !ackQ);

endmodule

`default_nettype wire

//--- logic/flushSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module flushSequencer (
    input  wire     clk,
    input  wire     rst,
    input  wire     start,
    input  wire     wrap,
    output logic    clearPtr,
    output logic    flushing
);
    import bpuBusPkg::*;

    flushStateE state;
    flushStateE stateNext;

    always_comb begin
        stateNext = state;
        case (state)
            FL_IDLE: begin
                if (start)
                    stateNext = FL_CLEAR;
            end
            FL_CLEAR: begin
                stateNext = FL_WALK;
            end
            FL_WALK: begin
                // pointer came back round, every entry has been visited
                if (wrap)
                    stateNext = FL_IDLE;
            end
            default: begin
                stateNext = FL_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst)
            state <= FL_IDLE;
        else
            state <= stateNext;
    end

    assign clearPtr = state == FL_CLEAR;
    assign flushing = state != FL_IDLE;

endmodule

`default_nettype wire

//--- logic/replacePointer.sv
`timescale 1ns/1ps
`include "bpu_consts.svh"
`default_nettype none

module replacePointer (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         clear,
    input  wire                         step,
    output logic [`BTB_IDX_BITS-1:0]    idx,
    output logic                        wrap
);

    // last entry rolls over to 0
    assign wrap = step && idx == `BTB_IDX_BITS'(`BTB_ENTRIES - 1);

    always_ff @(posedge clk) begin
        if (rst || clear)
            idx <= '0;
        else if (wrap)
            idx <= '0;
        else if (step)
            idx <= idx + 1'b1;
    end

    // flush clears the pointer in a cycle where nothing else moves it
    assert property (@(posedge clk) disable iff (rst) !(clear && step));

endmodule

`default_nettype wire

//--- logic/btbArray.sv
`timescale 1ns/1ps
`include "bpu_consts.svh"
`default_nettype none

module btbArray (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         lookupValid,
    input  wire [31:0]                  pc,
    output bpuTypesPkg::predictT        pred,
    input  wire bpuTypesPkg::resolveT   resolve,
    input  wire bpuTypesPkg::commitT    commit,
    input  wire [`BTB_IDX_BITS-1:0]     victimIdx,
    input  wire                         flushing,
    output logic                        victimBusy,
    output logic                        allocated,
    output logic                        branchCommitted
);
    import bpuTypesPkg::*;

    btbEntry                    entries [`BTB_ENTRIES];
    btbEntry                    commitEntry;
    logic [`BTB_IDX_BITS-1:0]   commitIdx;
    logic [1:0]                 commitHist;
    logic [1:0]                 commitCtr;
    logic [1:0]                 ctrNext;
    logic                       commitHit;

    // parallel lookup, lowest slot at or above the pc slot wins
    always_comb begin
        pred = '0;
        if (lookupValid) begin
            for (int i = 0; i < `BTB_ENTRIES; i++) begin
                if (entries[i].valid &&
                    entries[i].srcAddr[31:`FETCH_GROUP_BITS] == pc[31:`FETCH_GROUP_BITS] &&
                    entries[i].srcAddr[`SLOT_BIT] >= pc[`SLOT_BIT]) begin
                    if (pred.found)
                        pred.multiple = 1'b1;
                    if (!pred.found || entries[i].srcAddr[`SLOT_BIT] < pred.src[`SLOT_BIT]) begin
                        pred.found  = 1'b1;
                        pred.taken  = entries[i].isJump ||
                                      entries[i].counters[entries[i].history][1];
                        pred.isJump = entries[i].isJump;
                        pred.src    = entries[i].srcAddr;
                        pred.dst    = entries[i].dstAddr;
                        pred.id     = `BTB_ID_BITS'(i);
                    end
                end
            end
        end
    end

    // resolves are dropped while a flush runs
    assign allocated  = resolve.valid && resolve.taken && !flushing &&
                        resolve.id == `BTB_ID_BITS'(`BTB_NO_ENTRY);
    assign victimBusy = !flushing && entries[victimIdx].valid && entries[victimIdx].used;

    assign commitIdx   = commit.id[`BTB_IDX_BITS-1:0];
    assign commitEntry = entries[commitIdx];
    assign commitHist  = commitEntry.history;
    assign commitCtr   = commitEntry.counters[commitHist];
    assign commitHit   = commit.valid && commit.isBranch &&
                         commit.id != `BTB_ID_BITS'(`BTB_NO_ENTRY) &&
                         {commit.addr, 2'b00} == commitEntry.srcAddr;

    // saturating 2-bit counter step
    always_comb begin
        if (commit.taken)
            ctrNext = (commitCtr == 2'b11) ? commitCtr : commitCtr + 2'b01;
        else
            ctrNext = (commitCtr == 2'b00) ? commitCtr : commitCtr - 2'b01;
    end

    always_ff @(posedge clk) begin
        branchCommitted <= 1'b0;
        if (rst) begin
            for (int i = 0; i < `BTB_ENTRIES; i++) begin
                entries[i].valid <= 1'b0;
                entries[i].used  <= 1'b0;
            end
        end else begin
            if (allocated) begin
                entries[victimIdx] <= '{
                    valid:    1'b1,
                    used:     1'b1,
                    srcAddr:  resolve.addr,
                    dstAddr:  resolve.dest,
                    isJump:   resolve.isJump,
                    history:  {2{resolve.taken}},
                    counters: {4{{2{resolve.taken}}}}
                };
            end else if (victimBusy) begin
                // sweep passes this entry, give it one more round
                entries[victimIdx].used <= 1'b0;
            end

            if (flushing)
                entries[victimIdx].valid <= 1'b0;

            if (commitHit) begin
                entries[commitIdx].counters[commitHist] <= ctrNext;
                entries[commitIdx].history <= {commitHist[0], commit.taken};
                branchCommitted <= !commitEntry.isJump;
            end

            if (pred.taken)
                entries[pred.id[`BTB_IDX_BITS-1:0]].used <= 1'b1;
        end
    end

    // ids from the back end come from this array or are the no-entry code
    assert property (@(posedge clk) disable iff (rst)
        resolve.valid |-> (resolve.id < `BTB_ENTRIES ||
                           resolve.id == `BTB_ID_BITS'(`BTB_NO_ENTRY)));

    assert property (@(posedge clk) disable iff (rst)
        (commit.valid && commit.isBranch) |-> (commit.id < `BTB_ENTRIES ||
                                               commit.id == `BTB_ID_BITS'(`BTB_NO_ENTRY)));

endmodule

`default_nettype wire

//--- logic/bpuBusPkg.sv
`include "bpu_consts.svh"
`default_nettype none

package bpuBusPkg;

    // wishbone classic, master to slave
    typedef struct packed {
        logic                       cyc;
        logic                       stb;
        logic                       we;
        logic [`REG_ADDR_BITS-1:0]  adr;
        logic [31:0]                dat;
    } wbReqT;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wbRspT;

    typedef enum logic [`REG_ADDR_BITS-1:0] {
        REG_CTRL    = `REG_CTRL_ADDR,
        REG_STATUS  = `REG_STATUS_ADDR,
        REG_COMMITS = `REG_COMMITS_ADDR,
        REG_INSERTS = `REG_INSERTS_ADDR
    } csrAddrE;

    typedef enum logic [1:0] {
        FL_IDLE,
        FL_CLEAR,
        FL_WALK
    } flushStateE;

endpackage

`default_nettype wire

//--- logic/bpuTypesPkg.sv
`include "bpu_consts.svh"
`default_nettype none

package bpuTypesPkg;

    // one btb entry
    typedef struct packed {
        logic                     valid;
        // set on allocation and on taken hits, cleared by the sweep
        logic                     used;
        logic [31:0]              srcAddr;
        logic [31:0]              dstAddr;
        // always taken, counters ignored
        logic                     isJump;
        logic [1:0]               history;
        logic [3:0][1:0]          counters;
    } btbEntry;

    // answer to a fetch lookup
    typedef struct packed {
        logic                     found;
        logic                     taken;
        logic                     isJump;
        logic                     multiple;
        logic [31:0]              src;
        logic [31:0]              dst;
        logic [`BTB_ID_BITS-1:0]  id;
    } predictT;

    // branch unit report
    typedef struct packed {
        logic                     valid;
        logic [`BTB_ID_BITS-1:0]  id;
        logic [31:0]              addr;
        logic [31:0]              dest;
        logic                     taken;
        logic                     isJump;
    } resolveT;

    // reorder buffer commit, addr is a word address
    typedef struct packed {
        logic                     valid;
        logic                     isBranch;
        logic [`BTB_ID_BITS-1:0]  id;
        logic [29:0]              addr;
        logic                     taken;
    } commitT;

endpackage

`default_nettype wire

//--- logic/bpu_consts.svh
`ifndef BPU_CONSTS_SVH
`define BPU_CONSTS_SVH

`default_nettype none

// btb geometry, the 6-bit id space leaves room for the no-entry code
`define BTB_ENTRIES      32
`define BTB_IDX_BITS     5
`define BTB_ID_BITS      6
`define BTB_NO_ENTRY     63

// fetch group is 8 bytes, bit 2 picks the slot
`define FETCH_GROUP_BITS 3
`define SLOT_BIT         2

// statistics counters
`define CNT_BITS         16

// register port addresses
`define REG_ADDR_BITS    4
`define REG_CTRL_ADDR    0
`define REG_STATUS_ADDR  1
`define REG_COMMITS_ADDR 2
`define REG_INSERTS_ADDR 3

`default_nettype wire

`endif
